// ==== logic/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// Operand width, one word per operand
`define ALU_WIDTH 32

// Restoring divide steps, one quotient bit each
`define ALU_DIV_STEPS 32

`endif

// ==== logic/alu_pkg.sv ====
`include "alu_cfg.svh"

package alu_pkg;

   // Opcode encodings of the execute stage
   typedef enum logic [4:0] {
      OP_ADD = 5'b00011,
      OP_SUB = 5'b00100,
      OP_AND = 5'b00101,
      OP_OR  = 5'b00110,
      OP_SHR = 5'b00111,
      OP_ASR = 5'b01000,
      OP_SHL = 5'b01001,
      OP_ROR = 5'b01010,
      OP_ROL = 5'b01011,
      OP_MUL = 5'b01111,
      OP_DIV = 5'b10000,
      OP_NEG = 5'b10001,
      OP_NOT = 5'b10010
   } alu_op_e;

   // Remainder on top, quotient or single-word result below
   typedef struct packed {
      logic [`ALU_WIDTH-1:0] hi;
      logic [`ALU_WIDTH-1:0] lo;
   } z_halves_t;

   // Z word, read as one product or as two halves
   typedef union packed {
      logic [2*`ALU_WIDTH-1:0] full;
      z_halves_t               halves;
   } z_word_u;

endpackage

// ==== logic/exec_if.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

interface exec_if;

   // Latched operands and opcode
   logic [`ALU_WIDTH-1:0] a;
   logic [`ALU_WIDTH-1:0] b;
   alu_pkg::alu_op_e      opcode;

   // Single-cycle ALU result
   alu_pkg::z_word_u      alu_result;

   modport src (
      output a,
      output b,
      output opcode,
      input  alu_result
   );

   modport alu (
      input  a,
      input  b,
      input  opcode,
      output alu_result
   );

   // Divider only needs the operands
   modport div (
      input  a,
      input  b
   );

endinterface

// ==== logic/alu.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

module alu (
   exec_if.alu ops
);

   localparam int W = `ALU_WIDTH;

   // Shift amount is the low five bits of b
   logic [4:0]     sh;
   logic [2*W-1:0] rot_l;
   logic [2*W-1:0] rot_r;

   assign sh = ops.b[4:0];

   // Rotates work on a doubled copy of a
   assign rot_l = {ops.a, ops.a} << sh;
   assign rot_r = {ops.a, ops.a} >> sh;

   always_comb begin
      ops.alu_result = '0;
      case (ops.opcode)
         alu_pkg::OP_AND: begin
            ops.alu_result.halves.lo = ops.a & ops.b;
         end
         alu_pkg::OP_OR: begin
            ops.alu_result.halves.lo = ops.a | ops.b;
         end
         alu_pkg::OP_ADD: begin
            ops.alu_result.halves.lo = ops.a + ops.b;
         end
         alu_pkg::OP_SUB: begin
            ops.alu_result.halves.lo = ops.a - ops.b;
         end
         alu_pkg::OP_MUL: begin
            // Unsigned product fills both halves
            ops.alu_result.full = {{W{1'b0}}, ops.a} * {{W{1'b0}}, ops.b};
         end
         alu_pkg::OP_SHL: begin
            ops.alu_result.halves.lo = ops.a << sh;
         end
         alu_pkg::OP_SHR: begin
            ops.alu_result.halves.lo = ops.a >> sh;
         end
         alu_pkg::OP_ASR: begin
            ops.alu_result.halves.lo = $unsigned($signed(ops.a) >>> sh);
         end
         alu_pkg::OP_ROL: begin
            ops.alu_result.halves.lo = rot_l[2*W-1:W];
         end
         alu_pkg::OP_ROR: begin
            ops.alu_result.halves.lo = rot_r[W-1:0];
         end
         alu_pkg::OP_NEG: begin
            ops.alu_result.halves.lo = ~ops.a + 1'b1;
         end
         alu_pkg::OP_NOT: begin
            ops.alu_result.halves.lo = ~ops.a;
         end
         // Divide comes from the sequential divider
         default: begin
            ops.alu_result = '0;
         end
      endcase
   end

endmodule

// ==== logic/divider_seq.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

module divider_seq (
   input  logic                  clk,
   input  logic                  rst_n,
   exec_if.div                   ops,
   input  logic                  load,
   input  logic                  step,
   output logic [`ALU_WIDTH-1:0] quotient,
   output logic [`ALU_WIDTH-1:0] remainder
);

   localparam int W = `ALU_WIDTH;

   logic [W-1:0] rem_q;
   logic [W-1:0] dvd_q;
   logic [W:0]   shifted;
   logic [W:0]   trial;

   // Next dividend bit enters the partial remainder
   assign shifted = {rem_q, dvd_q[W-1]};
   assign trial   = shifted - {1'b0, ops.b};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rem_q <= '0;
         dvd_q <= '0;
      end else if (load) begin
         rem_q <= '0;
         dvd_q <= ops.a;
      end else if (step) begin
         // Borrow out means restore
         if (!trial[W]) begin
            rem_q <= trial[W-1:0];
            dvd_q <= {dvd_q[W-2:0], 1'b1};
         end else begin
            rem_q <= shifted[W-1:0];
            dvd_q <= {dvd_q[W-2:0], 1'b0};
         end
      end
   end

   // Dividend register ends up holding the quotient
   assign quotient  = dvd_q;
   assign remainder = rem_q;

   a_load_step_excl: assert property (
      @(posedge clk) disable iff (!rst_n) !(load && step)
   );

endmodule

// ==== logic/step_counter.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

module step_counter (
   input  logic clk,
   input  logic rst_n,
   input  logic clear,
   input  logic enable,
   output logic last
);

   localparam int STEPS = `ALU_DIV_STEPS;
   localparam int CW    = $clog2(STEPS + 1);

   logic [CW-1:0] count_q;

   // Final step of the run
   assign last = enable && (count_q == CW'(STEPS - 1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count_q <= '0;
      end else if (clear || last) begin
         count_q <= '0;
      end else if (enable) begin
         count_q <= count_q + 1'b1;
      end
   end

   a_count_range: assert property (
      @(posedge clk) disable iff (!rst_n) count_q <= CW'(STEPS - 1)
   );

endmodule

// ==== logic/exec_ctrl_fsm.sv ====
`timescale 1ns/1ns

module exec_ctrl_fsm (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             start,
   input  alu_pkg::alu_op_e opcode,
   input  logic             last,
   output logic             latch,
   output logic             div_load,
   output logic             div_step,
   output logic             cap_alu,
   output logic             cap_div,
   output logic             busy,
   output logic             done
);

   typedef enum logic [2:0] {IDLE, EXEC, DIV_LOAD, DIV_RUN, WRITE} state_e;

   state_e state_q;
   state_e state_d;
   logic   is_div_q;

   // Only an idle stage accepts a start
   assign latch    = (state_q == IDLE) && start;
   assign div_load = (state_q == DIV_LOAD);
   assign div_step = (state_q == DIV_RUN);
   assign cap_alu  = (state_q == EXEC) && !is_div_q;
   assign cap_div  = (state_q == EXEC) && is_div_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (start) begin
               state_d = (opcode == alu_pkg::OP_DIV) ? DIV_LOAD : EXEC;
            end
         end
         DIV_LOAD: state_d = DIV_RUN;
         DIV_RUN: begin
            if (last) begin
               state_d = EXEC;
            end
         end
         EXEC:     state_d = WRITE;
         default:  state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q  <= IDLE;
         is_div_q <= 1'b0;
         busy     <= 1'b0;
         done     <= 1'b0;
      end else begin
         state_q <= state_d;
         if (latch) begin
            is_div_q <= (opcode == alu_pkg::OP_DIV);
         end
         busy <= (state_d != IDLE);
         // Done marks the cycle after Z capture
         done <= (state_d == WRITE);
      end
   end

   a_done_pulse: assert property (
      @(posedge clk) disable iff (!rst_n) done |=> !done
   );

   // ALU capture follows the operand latch directly
   a_cap_alu_after_latch: assert property (
      @(posedge clk) disable iff (!rst_n) cap_alu |-> $past(latch)
   );

   // Divide capture follows the final step
   a_cap_div_after_last: assert property (
      @(posedge clk) disable iff (!rst_n) cap_div |-> $past(div_step && last)
   );

endmodule

// ==== logic/exec_regs.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

module exec_regs (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`ALU_WIDTH-1:0] a_in,
   input  logic [`ALU_WIDTH-1:0] b_in,
   input  alu_pkg::alu_op_e      opcode_in,
   input  logic                  latch,
   input  logic                  cap_alu,
   input  logic                  cap_div,
   input  logic [`ALU_WIDTH-1:0] quotient,
   input  logic [`ALU_WIDTH-1:0] remainder,
   exec_if.src                   ops,
   output alu_pkg::z_word_u      z
);

   // Operand and opcode latches
   always_ff @(posedge clk) begin
      if (latch) begin
         ops.a      <= a_in;
         ops.b      <= b_in;
         ops.opcode <= opcode_in;
      end
   end

   // Z holds until the next capture
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         z <= '0;
      end else if (cap_alu) begin
         z <= ops.alu_result;
      end else if (cap_div) begin
         z.halves.hi <= remainder;
         z.halves.lo <= quotient;
      end
   end

endmodule

// ==== logic/exec_unit.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

module exec_unit (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   input  logic [`ALU_WIDTH-1:0] a,
   input  logic [`ALU_WIDTH-1:0] b,
   input  logic [4:0]            opcode,
   output logic                  busy,
   output logic                  done,
   output logic [`ALU_WIDTH-1:0] z_hi,
   output logic [`ALU_WIDTH-1:0] z_lo
);

   alu_pkg::alu_op_e      op_in;
   alu_pkg::z_word_u      z;
   logic                  latch;
   logic                  div_load;
   logic                  div_step;
   logic                  cap_alu;
   logic                  cap_div;
   logic                  last;
   logic [`ALU_WIDTH-1:0] quotient;
   logic [`ALU_WIDTH-1:0] remainder;

   exec_if ops ();

   assign op_in = alu_pkg::alu_op_e'(opcode);

   exec_ctrl_fsm u_fsm (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .opcode   (op_in),
      .last     (last),
      .latch    (latch),
      .div_load (div_load),
      .div_step (div_step),
      .cap_alu  (cap_alu),
      .cap_div  (cap_div),
      .busy     (busy),
      .done     (done)
   );

   exec_regs u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .a_in      (a),
      .b_in      (b),
      .opcode_in (op_in),
      .latch     (latch),
      .cap_alu   (cap_alu),
      .cap_div   (cap_div),
      .quotient  (quotient),
      .remainder (remainder),
      .ops       (ops.src),
      .z         (z)
   );

   alu u_alu (
      .ops (ops.alu)
   );

   divider_seq u_div (
      .clk       (clk),
      .rst_n     (rst_n),
      .ops       (ops.div),
      .load      (div_load),
      .step      (div_step),
      .quotient  (quotient),
      .remainder (remainder)
   );

   // Load restarts the step count
   step_counter u_cnt (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (div_load),
      .enable (div_step),
      .last   (last)
   );

   assign z_hi = z.halves.hi;
   assign z_lo = z.halves.lo;

endmodule

// ==== verif/exec_unit_tb.sv ====
`timescale 1ns/1ns
`include "alu_cfg.svh"

module exec_unit_tb;

   localparam int W = `ALU_WIDTH;
   // Corner, random, zero divisor, undefined opcode and busy-start operations
   localparam int N_OPS = 13 * 4 + 13 * 8 + 4 + 4 + 2;
   localparam int TIMEOUT_CYCLES = 40 * N_OPS + 100;

   logic           clk;
   logic           rst_n;
   logic           start;
   logic [W-1:0]   a;
   logic [W-1:0]   b;
   logic [4:0]     opcode;
   logic           busy;
   logic           done;
   logic [W-1:0]   z_hi;
   logic [W-1:0]   z_lo;

   integer         seed;
   string          test_name;
   logic [2*W-1:0] exp_z;
   int             exp_lat;
   int             lat_cnt;
   bit             op_active;
   int             done_count;
   int             ops_issued = 0;
   int             cycle_count = 0;
   logic [4:0]     op_list [13];
   logic [W-1:0]   corner [4];

   exec_unit DUT (
      .clk    (clk),
      .rst_n  (rst_n),
      .start  (start),
      .a      (a),
      .b      (b),
      .opcode (opcode),
      .busy   (busy),
      .done   (done),
      .z_hi   (z_hi),
      .z_lo   (z_lo)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic mismatch_fail(input string name, input logic [2*W-1:0] expected,
                                input logic [2*W-1:0] actual);
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
   endtask

   task automatic plain_fail(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "protocol error");
   endtask

   // Reference results straight from the operation rules
   function automatic logic [2*W-1:0] expected_z(input logic [4:0] op, input logic [W-1:0] x,
                                                 input logic [W-1:0] y);
      logic signed [W-1:0] sx;
      logic [4:0]          s;
      logic [W-1:0]        hi;
      logic [W-1:0]        lo;
      sx = x;
      s  = y[4:0];
      hi = '0;
      lo = '0;
      case (op)
         alu_pkg::OP_AND: lo = x & y;
         alu_pkg::OP_OR:  lo = x | y;
         alu_pkg::OP_ADD: lo = x + y;
         alu_pkg::OP_SUB: lo = x - y;
         alu_pkg::OP_NEG: lo = {W{1'b0}} - x;
         alu_pkg::OP_NOT: lo = ~x;
         alu_pkg::OP_SHL: lo = x << s;
         alu_pkg::OP_SHR: lo = x >> s;
         alu_pkg::OP_ASR: lo = sx >>> s;
         alu_pkg::OP_ROL: lo = (x << s) | (x >> (W - s));
         alu_pkg::OP_ROR: lo = (x >> s) | (x << (W - s));
         alu_pkg::OP_MUL: {hi, lo} = (2*W)'(x) * (2*W)'(y);
         alu_pkg::OP_DIV: begin
            if (y == '0) begin
               hi = x;
               lo = '1;
            end else begin
               hi = x % y;
               lo = x / y;
            end
         end
         default: lo = '0;
      endcase
      return {hi, lo};
   endfunction

   // Expected acceptance, latency and done count of the stage
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         lat_cnt    <= 0;
         op_active  <= 1'b0;
         done_count <= 0;
      end else begin
         if (start && !op_active) begin
            lat_cnt   <= 1;
            op_active <= 1'b1;
         end else if (op_active) begin
            lat_cnt <= lat_cnt + 1;
         end
         if (done) begin
            op_active  <= 1'b0;
            done_count <= done_count + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TB FAILED");
         $fatal(1, "timeout");
      end
   end

   a_result: assert property (
      @(posedge clk) disable iff (!rst_n) done |-> ({z_hi, z_lo} == exp_z)
   ) else mismatch_fail(test_name, exp_z, $sampled({z_hi, z_lo}));

   a_latency: assert property (
      @(posedge clk) disable iff (!rst_n) done |-> (lat_cnt == exp_lat)
   ) else mismatch_fail({test_name, " latency"}, exp_lat, $sampled(lat_cnt));

   a_done_once: assert property (
      @(posedge clk) disable iff (!rst_n) done |=> !done
   ) else plain_fail("done stayed high for more than one cycle");

   a_busy: assert property (
      @(posedge clk) disable iff (!rst_n) busy == op_active
   ) else plain_fail("busy did not cover the operation in flight");

   // Z only moves together with a done pulse
   a_z_hold: assert property (
      @(posedge clk) disable iff (!rst_n) !$stable({z_hi, z_lo}) |-> done
   ) else plain_fail("Z changed without a done pulse");

   task automatic run_op(input string name, input logic [4:0] op, input logic [W-1:0] a_v,
                         input logic [W-1:0] b_v, input bit poke);
      test_name  = name;
      exp_z      = expected_z(op, a_v, b_v);
      exp_lat    = (op == alu_pkg::OP_DIV) ? `ALU_DIV_STEPS + 3 : 2;
      ops_issued = ops_issued + 1;
      a          = a_v;
      b          = b_v;
      opcode     = op;
      start      = 1'b1;
      @(negedge clk);
      if (poke) begin
         // Second request arrives while busy
         a      = ~a_v;
         b      = a_v ^ b_v;
         opcode = alu_pkg::OP_MUL;
         @(negedge clk);
      end
      start = 1'b0;
      while (done !== 1'b1) @(negedge clk);
      @(negedge clk);
   endtask

   initial begin
      logic [W-1:0] ra;
      logic [W-1:0] rb;
      seed     = 32'h2ebc220c;
      op_list  = '{alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_ADD, alu_pkg::OP_SUB,
                   alu_pkg::OP_NEG, alu_pkg::OP_NOT, alu_pkg::OP_MUL, alu_pkg::OP_SHL,
                   alu_pkg::OP_SHR, alu_pkg::OP_ASR, alu_pkg::OP_ROL, alu_pkg::OP_ROR,
                   alu_pkg::OP_DIV};
      corner   = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h0000_001f};
      rst_n    = 1'b0;
      start    = 1'b0;
      a        = '0;
      b        = '0;
      opcode   = '0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      assert (busy == 1'b0 && done == 1'b0) else plain_fail("busy or done high after reset");
      assert ({z_hi, z_lo} == '0) else mismatch_fail("reset Z", '0, {z_hi, z_lo});

      // Corner pairs, the last one has a zero divisor
      for (int k = 0; k < 13; k++) begin
         for (int i = 0; i < 4; i++) begin
            run_op($sformatf("op %02h corner %0d", op_list[k], i), op_list[k],
                   corner[i], corner[(i + 1) % 4], 1'b0);
         end
      end

      for (int k = 0; k < 13; k++) begin
         for (int i = 0; i < 8; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            // Smaller divisors give wider quotients
            if (op_list[k] == alu_pkg::OP_DIV) begin
               rb = rb >> ra[4:0];
            end
            run_op($sformatf("op %02h random %0d", op_list[k], i), op_list[k], ra, rb, 1'b0);
         end
      end

      for (int i = 0; i < 4; i++) begin
         ra = $random(seed);
         run_op($sformatf("div by zero %0d", i), alu_pkg::OP_DIV, ra, '0, 1'b0);
      end

      run_op("undefined 00", 5'h00, 32'h1234_5678, 32'h9abc_def0, 1'b0);
      run_op("undefined 01", 5'h01, 32'hffff_ffff, 32'h0000_0001, 1'b0);
      run_op("undefined 0c", 5'h0c, 32'h8000_0000, 32'h0000_001f, 1'b0);
      run_op("undefined 1f", 5'h1f, 32'hdead_beef, 32'hcafe_f00d, 1'b0);

      run_op("add start while busy", alu_pkg::OP_ADD, 32'h0000_00ff, 32'h0000_0101, 1'b1);
      run_op("div start while busy", alu_pkg::OP_DIV, 32'h0001_0000, 32'h0000_0007, 1'b1);

      if (done_count != ops_issued) begin
         mismatch_fail("done count", ops_issued, done_count);
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/alu_pkg.sv
logic/exec_if.sv
logic/alu.sv
logic/divider_seq.sv
logic/step_counter.sv
logic/exec_ctrl_fsm.sv
logic/exec_regs.sv
logic/exec_unit.sv
verif/exec_unit_tb.sv
